// File: sources.f
+incdir+include
hdl/pibus_pkg.sv
hdl/pibus_master.sv
hdl/pibus_arbiter.sv
hdl/pibus_mem_slave.sv
hdl/pibus_subsystem.sv
tb/tb_clkgen.sv
tb/tb_pibus_props.sv
tb/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the Pi-bus testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_top \
   -Mdir obj_dir -o tb_top_sim \
   && obj_dir/tb_top_sim +verilator+error+limit+1000 | tee /dev/stderr \
      | grep -q "All tests passed" \
   && { echo "run_sim: PASS"; exit 0; } \
   || { echo "run_sim: FAIL"; exit 1; }

// File: tb/tb_top.sv
// Pi-bus segment testbench
`include "pibus_consts.svh"

module tb_top
   import pibus_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        rst_n;
   logic        req_ext;
   logic        gnt_ext;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;

   int          seed = 35531;
   int          val_errs = 0;
   int          other_errs = 0;
   logic [31:0] model [`PIBUS_MEM_WORDS];   // expected memory contents
   logic [29:0] written [$];

   tb_clkgen clkgen0 (.clk(clk), .rst_n(rst_n));

   pibus_subsystem dut0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .wb_req  (wb_req),
      .req_ext (req_ext),
      .wb_rsp  (wb_rsp),
      .gnt_ext (gnt_ext)
   );

   // one wishbone cycle, called on a falling edge
   task automatic bus_access(input string name, input logic we, input logic [29:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      int   n;
      logic fin;
      logic got_err;
      logic exp_err;
      n = 0;
      fin = 1'b0;
      got_err = 1'b0;
      rdat = '0;
      exp_err = (adr >= 30'(`PIBUS_STALL_BASE));   // stall and error ranges both end in err
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      while (!fin && n < 100)
      begin
         @(negedge clk);
         n++;
         if (wb_rsp.ack || wb_rsp.err)
         begin
            fin = 1'b1;
            got_err = wb_rsp.err;
            rdat = wb_rsp.dat;
         end
      end
      wb_req = '0;
      @(negedge clk);   // stb low for one cycle
      if (!fin)
      begin
         other_errs++;
         $display("%s: no ack or err within 100 cycles at address %0d", name, adr);
      end
      else if (got_err != exp_err)
      begin
         other_errs++;
         $display("%s: access at address %0d ended with the wrong response", name, adr);
      end
      else if (we && !exp_err)
         model[adr[5:0]] = wdat;
   endtask

   task automatic read_back(input string name, input logic [29:0] adr);
      logic [31:0] rd;
      bus_access(name, 1'b0, adr, '0, rd);
      if (rd !== model[adr[5:0]])
      begin
         val_errs++;
         $display("error %s expected %h actual %h", name, model[adr[5:0]], rd);
      end
   endtask

   initial
   begin
      logic [31:0] rd;
      logic [29:0] a;
      int          n;
      wb_req = '0;
      req_ext = 1'b0;
      n = 0;
      while (rst_n !== 1'b1 && n < 50)
      begin
         @(negedge clk);
         n++;
      end
      if (rst_n !== 1'b1)
      begin
         other_errs++;
         $display("reset was never released");
      end

      for (int i = 0; i < 8; i++)
      begin
         a = 30'($random(seed)) & 30'h2f;   // retry bit clear
         bus_access("write_read", 1'b1, a, $random(seed), rd);
         written.push_back(a);
      end
      foreach (written[i])
         read_back("write_read", written[i]);

      for (int w = 0; w < 4; w++)
      begin
         a = 30'd32 + 30'(w);
         bus_access("wait_states", 1'b1, a, $random(seed), rd);
         written.push_back(a);
         read_back("wait_states", a);
      end

      bus_access("retry", 1'b1, 30'd21, $random(seed), rd);
      bus_access("retry", 1'b1, 30'd50, $random(seed), rd);
      written.push_back(30'd21);
      written.push_back(30'd50);
      read_back("retry", 30'd21);
      read_back("retry", 30'd50);

      bus_access("error_range", 1'b1, 30'd130, $random(seed), rd);
      bus_access("error_range", 1'b0, 30'd200, '0, rd);
      foreach (written[i])
         read_back("error_range", written[i]);   // nothing may have changed

      bus_access("timeout", 1'b0, 30'd70, '0, rd);
      bus_access("timeout", 1'b1, 30'd127, $random(seed), rd);

      // external requester owns the bus first
      req_ext = 1'b1;
      n = 0;
      while (!gnt_ext && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      if (!gnt_ext)
      begin
         other_errs++;
         $display("arbitration: external requester was never granted");
      end
      fork
         bus_access("arbitration", 1'b1, 30'd9, $random(seed), rd);
         begin
            repeat (20) @(negedge clk);
            req_ext = 1'b0;
         end
      join
      read_back("arbitration", 30'd9);

      $display("errors: value %0d, other %0d, assertion %0d",
               val_errs, other_errs, dut0.props0.fail_cnt);
      if (val_errs + other_errs + dut0.props0.fail_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// File: tb/tb_pibus_props.sv
// Pi-bus protocol assertions
`include "pibus_consts.svh"

module tb_pibus_props
   import pibus_pkg::*;
(
   input logic     clk,
   input logic     rst_n,
   input wb_req_t  wb_req,
   input wb_rsp_t  wb_rsp,
   input logic     req_ext,
   input logic     gnt,
   input logic     gnt_ext,
   input logic     tout,
   input pi_addr_t pi_addr,
   input pi_rsp_t  pi_rsp
);
   timeunit 1ns;
   timeprecision 100ps;

   int          fail_cnt = 0;
   logic [29:0] last_a;     // address of the latest address phase
   logic [7:0]  dcnt;       // data-phase cycles so far, current one included
   logic [7:0]  wat_run;
   logic        rtr_open;   // retry seen, new address phase still due

   function automatic void note_fail(input string what);
      fail_cnt++;
      $error("%s", what);
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         dcnt     <= '0;
         wat_run  <= '0;
         rtr_open <= 1'b0;
      end
      else
      begin
         if (pi_addr.opc == OPC_WORD)
         begin
            last_a <= pi_addr.a;
            dcnt   <= 8'd1;
         end
         else if (pi_rsp.ack != ACK_IDLE)
            dcnt <= dcnt + 8'd1;
         wat_run <= (pi_rsp.ack == ACK_WAT) ? wat_run + 8'd1 : 8'd0;
         if (pi_rsp.ack == ACK_RTR)
            rtr_open <= 1'b1;
         else if (pi_addr.opc == OPC_WORD)
            rtr_open <= 1'b0;
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) !(wb_rsp.ack && wb_rsp.err))
      else note_fail("wishbone ack and err high in the same cycle");
   assert property (@(posedge clk) disable iff (!rst_n)
      (wb_rsp.ack || wb_rsp.err) |-> $past(wb_req.cyc && wb_req.stb))
      else note_fail("wishbone response without a strobe before it");
   assert property (@(posedge clk) disable iff (!rst_n)
      pi_addr.opc == OPC_WORD |=> pi_addr.opc == OPC_NOP)
      else note_fail("address phase longer than one cycle");
   // ready after w + 1 data cycles, w from address bits 1:0
   assert property (@(posedge clk) disable iff (!rst_n)
      pi_rsp.ack == ACK_RDY |-> dcnt == 8'(last_a[1:0]) + 8'd1)
      else note_fail("ready came after the wrong number of data-phase cycles");
   assert property (@(posedge clk) disable iff (!rst_n) pi_rsp.ack == ACK_RDY |=> wb_rsp.ack)
      else note_fail("wishbone ack did not follow ready");
   assert property (@(posedge clk) disable iff (!rst_n) rtr_open |-> !wb_rsp.ack)
      else note_fail("wishbone ack before the retried address phase");
   assert property (@(posedge clk) disable iff (!rst_n)
      (rtr_open && pi_addr.opc == OPC_WORD) |-> pi_addr.a == last_a)
      else note_fail("retried address phase at a different address");
   assert property (@(posedge clk) disable iff (!rst_n)
      tout |-> wat_run == 8'(`PIBUS_TOUT_CYCLES))
      else note_fail("bus timeout without the full run of wait responses");
   assert property (@(posedge clk) disable iff (!rst_n) !(gnt && gnt_ext))
      else note_fail("master and external requester granted together");
   // external owner keeps the bus while it still requests
   assert property (@(posedge clk) disable iff (!rst_n) (gnt_ext && req_ext) |=> gnt_ext)
      else note_fail("external grant taken away while still requested");

endmodule

bind pibus_subsystem tb_pibus_props props0 (
   .clk     (clk),
   .rst_n   (rst_n),
   .wb_req  (wb_req),
   .wb_rsp  (wb_rsp),
   .req_ext (req_ext),
   .gnt     (gnt),
   .gnt_ext (gnt_ext),
   .tout    (tout),
   .pi_addr (pi_addr),
   .pi_rsp  (pi_rsp)
);

// File: tb/tb_clkgen.sv
// Clock and reset source
module tb_clkgen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// File: hdl/pibus_subsystem.sv
// Pi-bus segment top
module pibus_subsystem
   import pibus_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  wb_req_t wb_req,
   input  logic    req_ext,
   output wb_rsp_t wb_rsp,
   output logic    gnt_ext
);

   logic        req;
   logic        gnt;
   logic        tout;
   pi_addr_t    pi_addr;
   pi_rsp_t     pi_rsp;
   logic [31:0] dout;

   pibus_master master0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .wb_req  (wb_req),
      .gnt     (gnt),
      .tout    (tout),
      .pi_rsp  (pi_rsp),
      .wb_rsp  (wb_rsp),
      .req     (req),
      .pi_addr (pi_addr),
      .dout    (dout)
   );

   // second requester comes from outside the segment
   pibus_arbiter arb0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .req_ext (req_ext),
      .pi_rsp  (pi_rsp),
      .gnt     (gnt),
      .gnt_ext (gnt_ext),
      .tout    (tout)
   );

   pibus_mem_slave mem0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .pi_addr (pi_addr),
      .din     (dout),
      .pi_rsp  (pi_rsp)
   );

endmodule

// File: hdl/pibus_mem_slave.sv
// Pi-bus memory slave
`include "pibus_consts.svh"

module pibus_mem_slave
   import pibus_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  pi_addr_t    pi_addr,
   input  logic [31:0] din,
   output pi_rsp_t     pi_rsp
);

   localparam int IDX_W = $clog2(`PIBUS_MEM_WORDS);
   localparam int CNT_W = $clog2(`PIBUS_TOUT_CYCLES + 1);

   typedef enum logic [1:0] {
      KIND_MEM,
      KIND_STALL,
      KIND_ERR,
      KIND_RTR
   } kind_e;

   logic [31:0] mem [`PIBUS_MEM_WORDS];

   logic             open;       // data phase in progress
   kind_e            kind;
   logic [CNT_W-1:0] wcnt;
   logic             rtr_pend;
   logic [29:0]      adr_q;
   logic             read_q;

   kind_e            kind_d;
   pi_ack_e          ack;
   logic [IDX_W-1:0] idx;
   logic             stall_done;
   logic [31:0]      rdata;

   assign idx = adr_q[IDX_W-1:0];

   // decode of the address phase
   always_comb
   begin
      if (pi_addr.a >= 30'(`PIBUS_ERR_BASE))
         kind_d = KIND_ERR;
      else if (pi_addr.a >= 30'(`PIBUS_STALL_BASE))
         kind_d = KIND_STALL;
      else if (pi_addr.a[`PIBUS_RETRY_BIT] && !rtr_pend)
         kind_d = KIND_RTR;
      else
         kind_d = KIND_MEM;
   end

   // a stall runs one cycle past the bus timeout, then the phase closes
   assign stall_done = (wcnt == CNT_W'(`PIBUS_TOUT_CYCLES));

   always_comb
   begin
      ack = ACK_IDLE;
      if (open)
      begin
         case (kind)
            KIND_ERR:   ack = ACK_ERR;
            KIND_RTR:   ack = ACK_RTR;
            KIND_STALL: ack = ACK_WAT;
            default:    ack = (wcnt == CNT_W'(adr_q[1:0])) ? ACK_RDY : ACK_WAT;
         endcase
      end
   end

   assign rdata  = (ack == ACK_RDY && read_q) ? mem[idx] : '0;
   assign pi_rsp = '{ack: ack, dat: rdata};

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         open     <= 1'b0;
         kind     <= KIND_MEM;
         wcnt     <= '0;
         rtr_pend <= 1'b0;
      end
      else if (pi_addr.opc == OPC_WORD)
      begin
         open <= 1'b1;
         kind <= kind_d;
         wcnt <= '0;
      end
      else if (open)
      begin
         if (ack == ACK_RTR)
            rtr_pend <= 1'b1;
         else if (ack == ACK_RDY)
            rtr_pend <= 1'b0;   // repeated attempt went through
         if (ack != ACK_WAT || (kind == KIND_STALL && stall_done))
            open <= 1'b0;
         else
            wcnt <= wcnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (pi_addr.opc == OPC_WORD)
      begin
         adr_q  <= pi_addr.a;
         read_q <= pi_addr.read;
      end
      if (ack == ACK_RDY && !read_q)
         mem[idx] <= din;   // write lands on ready
   end

endmodule

// File: hdl/pibus_arbiter.sv
// Pi-bus arbiter and bus timeout
`include "pibus_consts.svh"

module pibus_arbiter
   import pibus_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    req,
   input  logic    req_ext,
   input  pi_rsp_t pi_rsp,
   output logic    gnt,
   output logic    gnt_ext,
   output logic    tout
);

   localparam int TOUT_W = $clog2(`PIBUS_TOUT_CYCLES + 1);

   logic prio_ext;   // external side wins the next tie

   logic hold_m;
   logic hold_e;
   logic pick_m;
   logic pick_e;

   logic [TOUT_W-1:0] wat_cnt;

   // owner keeps the bus as long as it requests
   assign hold_m = gnt & req;
   assign hold_e = gnt_ext & req_ext;

   assign pick_m = req & (~req_ext | ~prio_ext);
   assign pick_e = req_ext & ~pick_m;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         gnt      <= 1'b0;
         gnt_ext  <= 1'b0;
         prio_ext <= 1'b0;
      end
      else if (!hold_m && !hold_e)
      begin
         gnt     <= pick_m;
         gnt_ext <= pick_e;
         if (pick_m)
            prio_ext <= 1'b1;
         else if (pick_e)
            prio_ext <= 1'b0;
      end
   end

   // counts back-to-back wait answers
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wat_cnt <= '0;
         tout    <= 1'b0;
      end
      else
      begin
         tout <= 1'b0;
         if (pi_rsp.ack != ACK_WAT)
            wat_cnt <= '0;
         else if (wat_cnt == TOUT_W'(`PIBUS_TOUT_CYCLES - 1))
         begin
            wat_cnt <= '0;
            tout    <= 1'b1;
         end
         else
            wat_cnt <= wat_cnt + 1'b1;
      end
   end

endmodule

// File: hdl/pibus_master.sv
// Pi-bus master controller
module pibus_master
   import pibus_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  wb_req_t     wb_req,
   input  logic        gnt,
   input  logic        tout,
   input  pi_rsp_t     pi_rsp,
   output wb_rsp_t     wb_rsp,
   output logic        req,
   output pi_addr_t    pi_addr,
   output logic [31:0] dout
);

   pi_mst_state_e state;

   logic        ack_q;
   logic        err_q;
   logic [31:0] rdat_q;

   // latched host request
   logic [29:0] adr_q;
   logic        we_q;
   logic [31:0] wdat_q;

   logic start;
   logic abort;
   logic done;

   // ack or err still showing means the host has not dropped stb yet
   assign start = (state == MST_IDLE) && wb_req.cyc && wb_req.stb && !ack_q && !err_q;

   // timeout wins over whatever the slave answers
   assign abort = (state == MST_DATA) && (tout || (pi_rsp.ack == ACK_ERR));
   assign done  = (state == MST_DATA) && !tout && (pi_rsp.ack == ACK_RDY);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= MST_IDLE;
         req   <= 1'b0;
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end
      else
      begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         case (state)
            MST_IDLE:
            begin
               if (start)
               begin
                  req   <= 1'b1;
                  state <= MST_REQ;
               end
            end
            MST_REQ:
            begin
               if (gnt)
                  state <= MST_ADDR;
            end
            MST_ADDR:
               state <= MST_DATA;   // single address cycle
            MST_DATA:
            begin
               if (abort)
               begin
                  req   <= 1'b0;
                  err_q <= 1'b1;
                  state <= MST_IDLE;
               end
               else if (done)
               begin
                  req   <= 1'b0;
                  ack_q <= 1'b1;
                  state <= MST_IDLE;
               end
               else if (pi_rsp.ack == ACK_RTR)
                  state <= MST_RTRCT;   // req stays up so the grant is kept
            end
            MST_RTRCT:
            begin
               if (gnt)
                  state <= MST_ADDR;
               else
                  state <= MST_REQ;
            end
            default:
            begin
               req   <= 1'b0;
               state <= MST_IDLE;
            end
         endcase
      end
   end

   // payload
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         adr_q  <= wb_req.adr;
         we_q   <= wb_req.we;
         wdat_q <= wb_req.dat;
      end
      if (done && !we_q)
         rdat_q <= pi_rsp.dat;
   end

   always_comb
   begin
      pi_addr.a    = '0;
      pi_addr.opc  = OPC_NOP;
      pi_addr.read = 1'b0;
      if (state == MST_ADDR)
      begin
         pi_addr.a    = adr_q;
         pi_addr.opc  = OPC_WORD;
         pi_addr.read = !we_q;
      end
   end

   assign dout = wdat_q;   // held until the slave takes it on ready

   assign wb_rsp = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

// File: hdl/pibus_pkg.sv
// Pi-bus types
package pibus_pkg;

   // slave response code
   typedef enum logic [2:0] {
      ACK_IDLE,
      ACK_RDY,
      ACK_WAT,
      ACK_RTR,
      ACK_ERR
   } pi_ack_e;

   typedef enum logic [3:0] {
      OPC_NOP  = 4'h0,   // no address phase
      OPC_WORD = 4'h1
   } pi_opc_e;

   typedef enum logic [2:0] {
      MST_IDLE,
      MST_REQ,
      MST_ADDR,
      MST_DATA,
      MST_RTRCT
   } pi_mst_state_e;

   // wishbone classic host side
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [29:0] adr;   // word address
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;
   } wb_rsp_t;

   // address phase
   typedef struct packed {
      logic [29:0] a;
      pi_opc_e     opc;
      logic        read;
   } pi_addr_t;

   typedef struct packed {
      pi_ack_e     ack;
      logic [31:0] dat;
   } pi_rsp_t;

endpackage

// File: include/pibus_consts.svh
// Pi-bus segment constants
`ifndef PIBUS_CONSTS_SVH
`define PIBUS_CONSTS_SVH

// memory slave map, word addresses
`define PIBUS_MEM_WORDS   64
`define PIBUS_STALL_BASE  64    // stall window start
`define PIBUS_ERR_BASE    128   // error range start

// first attempt answers retry when this address bit is set
`define PIBUS_RETRY_BIT   4

// consecutive wait responses before the bus timeout
`define PIBUS_TOUT_CYCLES 16

`endif
